// File: hw/wordGamePkg.sv
package wordGamePkg;

    // ########################################
    // Word geometry
    // ########################################

    localparam int wordLen = 5;                    // Letters per word.
    localparam int letterW = 8;                    // ASCII code width.
    localparam int wordW   = wordLen * letterW;    // Packed word width.

    // ########################################
    // Scoring limits
    // ########################################

    localparam int countW      = 3;                // Correct and mistake counts.
    localparam int winCount    = 5;                // All positions revealed.
    localparam int maxMistakes = 6;

    // Unrevealed positions show an underscore.
    localparam logic [letterW-1:0] blankCode = 8'h5F;

    // Seven-segment patterns, gfedcba, active high.
    localparam logic [6:0] segDigits [8] = '{
        7'h3F,                                     // 0.
        7'h06,                                     // 1.
        7'h5B,                                     // 2.
        7'h4F,                                     // 3.
        7'h66,                                     // 4.
        7'h6D,                                     // 5.
        7'h7D,                                     // 6.
        7'h07                                      // 7.
    };

endpackage

// File: hw/keyFilter.sv
`timescale 1ns/1ps

module keyFilter import wordGamePkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  logic [letterW-1:0] keyCode,
    input  logic               keyStrobe,
    output logic [letterW-1:0] letter,
    output logic               letterStrobe
);

    logic               isUpper;
    logic               isLower;
    logic [letterW-1:0] folded;

    assign isUpper = (keyCode >= 8'h41) && (keyCode <= 8'h5A);    // A to Z.
    assign isLower = (keyCode >= 8'h61) && (keyCode <= 8'h7A);    // a to z.

    // Clearing bit 5 would also work, but only inside the letter ranges.
    assign folded = isLower ? keyCode - 8'h20 : keyCode;

    // ########################################
    // Output register
    // ########################################

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            letterStrobe <= 1'b0;
        end else begin
            letterStrobe <= keyStrobe && (isUpper || isLower);
        end
    end

    always_ff @(posedge clk) begin
        if (keyStrobe) begin
            letter <= folded;                        // Held between strobes.
        end
    end

endmodule

// File: hw/wordLoader.sv
`timescale 1ns/1ps

module wordLoader import wordGamePkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  logic               setupMode,
    input  logic [letterW-1:0] letter,
    input  logic               letterStrobe,
    output logic [wordW-1:0]   word,
    output logic               wordReady
);

    logic [countW-1:0] loadCount;
    logic              setupModeQ;
    logic              shiftEn;
    logic              setupEntry;

    assign shiftEn    = setupMode && letterStrobe;
    assign setupEntry = setupMode && !setupModeQ;    // First cycle of setup.

    // ########################################
    // Load counter
    // ########################################

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            setupModeQ <= 1'b0;
            loadCount  <= '0;
        end else begin
            setupModeQ <= setupMode;
            if (setupEntry) begin
                // A letter arriving on the entry cycle still counts.
                loadCount <= {{(countW - 1){1'b0}}, shiftEn};
            end else if (shiftEn && !wordReady) begin
                loadCount <= loadCount + 1'b1;     // Saturates at five.
            end
        end
    end

    // ########################################
    // Word shift register
    // ########################################

    // Newest letter enters the low byte, so the first one typed
    // ends up in the top byte after five strobes.
    always_ff @(posedge clk) begin
        if (shiftEn) begin
            word <= {word[wordW-letterW-1:0], letter};
        end
    end

    assign wordReady = (loadCount == countW'(wordLen));

endmodule

// File: hw/gameLogic.sv
`timescale 1ns/1ps

module gameLogic import wordGamePkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  logic [wordW-1:0]   word,
    input  logic               wordReady,
    input  logic [letterW-1:0] letter,
    input  logic               letterStrobe,
    input  logic               startGame,
    input  logic               gameEnd,
    output logic               setupMode,
    output logic               ready,
    output logic               busy,
    output logic               mistake,
    output logic [countW-1:0]  correct,
    output logic [countW-1:0]  incorrect,
    output logic [wordLen-1:0] foundMask,
    output logic               winLamp,
    output logic               loseLamp
);

    typedef enum logic [3:0] {
        SETUP, FIRST, SCAN0, SCAN1, SCAN2, SCAN3, SCAN4, SCORE, IDLE
    } stateT;

    stateT              state;
    stateT              nextState;
    logic [letterW-1:0] guess;
    logic               guessPending;
    logic               acceptGuess;
    logic [2:0]         scanIdx;
    logic [letterW-1:0] scanByte;
    logic               scanHit;
    logic [countW-1:0]  hitCount;
    logic [wordLen-1:0] hitMask;
    logic               gameOver;

    assign setupMode = (state == SETUP);
    assign ready     = (state == FIRST) || (state == IDLE);
    assign busy      = (state >= SCAN0) && (state <= SCAN4);
    assign mistake   = (state == SCORE) && (hitCount == '0);

    // Only one guess may wait; the FSM takes it on the next edge.
    assign acceptGuess = ready && letterStrobe && !guessPending;

    assign gameOver = (correct == countW'(winCount)) ||
                      (incorrect == countW'(maxMistakes));

    // ########################################
    // Scan position
    // ########################################

    // Position 0 is the top byte, which pairs with mask bit 4.
    always_comb begin
        case (state)
            SCAN0:   scanIdx = 3'd4;
            SCAN1:   scanIdx = 3'd3;
            SCAN2:   scanIdx = 3'd2;
            SCAN3:   scanIdx = 3'd1;
            SCAN4:   scanIdx = 3'd0;
            default: scanIdx = 3'd0;
        endcase
    end

    assign scanByte = word[scanIdx*letterW +: letterW];
    assign scanHit  = busy && (scanByte == guess) && !foundMask[scanIdx];

    // ########################################
    // State machine
    // ########################################

    always_comb begin
        nextState = state;
        case (state)
            SETUP:   if (startGame && wordReady) nextState = FIRST;
            FIRST:   if (guessPending) nextState = SCAN0;
            SCAN0:   nextState = SCAN1;
            SCAN1:   nextState = SCAN2;
            SCAN2:   nextState = SCAN3;
            SCAN3:   nextState = SCAN4;
            SCAN4:   nextState = SCORE;
            SCORE:   nextState = IDLE;
            IDLE:    if (guessPending && !gameOver) nextState = SCAN0;
            default: nextState = SETUP;
        endcase
        if (gameEnd && (state != SETUP)) begin
            nextState = SETUP;                       // Host abort wins.
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state <= SETUP;
        end else begin
            state <= nextState;
        end
    end

    // ########################################
    // Scoring
    // ########################################

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            guessPending <= 1'b0;
            hitCount     <= '0;
            hitMask      <= '0;
            correct      <= '0;
            incorrect    <= '0;
            foundMask    <= '0;
            winLamp      <= 1'b0;
            loseLamp     <= 1'b0;
        end else begin
            guessPending <= acceptGuess;
            case (state)
                SETUP: begin
                    hitCount  <= '0;
                    hitMask   <= '0;
                    correct   <= '0;
                    incorrect <= '0;
                    foundMask <= '0;
                    winLamp   <= 1'b0;
                    loseLamp  <= 1'b0;
                end
                SCAN0, SCAN1, SCAN2, SCAN3, SCAN4: begin
                    if (scanHit) begin
                        hitCount         <= hitCount + 1'b1;
                        hitMask[scanIdx] <= 1'b1;
                    end
                end
                SCORE: begin
                    foundMask <= foundMask | hitMask;
                    if (hitCount != '0) begin
                        correct <= correct + hitCount;
                    end else begin
                        incorrect <= incorrect + 1'b1;    // Nothing new revealed.
                    end
                end
                IDLE: begin
                    hitCount <= '0;
                    hitMask  <= '0;
                    winLamp  <= (correct == countW'(winCount));
                    loseLamp <= (incorrect == countW'(maxMistakes));
                end
                default: begin
                    hitCount <= '0;
                    hitMask  <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (acceptGuess) begin
            guess <= letter;
        end
    end

endmodule

// File: hw/statusDisplay.sv
`timescale 1ns/1ps

module statusDisplay import wordGamePkg::*; (
    input  logic [wordW-1:0]   word,
    input  logic [wordLen-1:0] foundMask,
    input  logic [countW-1:0]  correct,
    input  logic [countW-1:0]  incorrect,
    output logic [wordW-1:0]   revealed,
    output logic [6:0]         segCorrect,
    output logic [6:0]         segIncorrect
);

    // ########################################
    // Revealed word
    // ########################################

    // Byte i of the word pairs with mask bit i.
    for (genvar i = 0; i < wordLen; i++) begin : gReveal
        assign revealed[i*letterW +: letterW] =
            foundMask[i] ? word[i*letterW +: letterW] : blankCode;
    end

    // ########################################
    // Count digits
    // ########################################

    assign segCorrect   = segDigits[correct];      // Three bits cover 0 to 7.
    assign segIncorrect = segDigits[incorrect];

endmodule

// File: hw/wordGameTop.sv
`timescale 1ns/1ps

module wordGameTop import wordGamePkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  logic [letterW-1:0] keyCode,
    input  logic               keyStrobe,
    input  logic               startGame,
    input  logic               gameEnd,
    output logic               ready,
    output logic               busy,
    output logic               mistake,
    output logic [countW-1:0]  correct,
    output logic [countW-1:0]  incorrect,
    output logic [wordW-1:0]   revealed,
    output logic [6:0]         segCorrect,
    output logic [6:0]         segIncorrect,
    output logic               winLamp,
    output logic               loseLamp
);

    logic [letterW-1:0] letter;
    logic               letterStrobe;
    logic               setupMode;
    logic [wordW-1:0]   word;
    logic               wordReady;
    logic [wordLen-1:0] foundMask;

    keyFilter uKeyFilter (
        .clk          (clk),
        .nRst         (nRst),
        .keyCode      (keyCode),
        .keyStrobe    (keyStrobe),
        .letter       (letter),
        .letterStrobe (letterStrobe)
    );

    wordLoader uWordLoader (
        .clk          (clk),
        .nRst         (nRst),
        .setupMode    (setupMode),
        .letter       (letter),
        .letterStrobe (letterStrobe),
        .word         (word),
        .wordReady    (wordReady)
    );

    gameLogic uGameLogic (
        .clk          (clk),
        .nRst         (nRst),
        .word         (word),
        .wordReady    (wordReady),
        .letter       (letter),
        .letterStrobe (letterStrobe),
        .startGame    (startGame),
        .gameEnd      (gameEnd),
        .setupMode    (setupMode),
        .ready        (ready),
        .busy         (busy),
        .mistake      (mistake),
        .correct      (correct),
        .incorrect    (incorrect),
        .foundMask    (foundMask),
        .winLamp      (winLamp),
        .loseLamp     (loseLamp)
    );

    statusDisplay uStatusDisplay (
        .word         (word),
        .foundMask    (foundMask),
        .correct      (correct),
        .incorrect    (incorrect),
        .revealed     (revealed),
        .segCorrect   (segCorrect),
        .segIncorrect (segIncorrect)
    );

endmodule

// File: sim/gameLogic_assert.sv
`timescale 1ns/1ps

module gameLogicAssert import wordGamePkg::*; (
    input logic              clk,
    input logic              nRst,
    input logic              gameEnd,
    input logic              ready,
    input logic              busy,
    input logic              mistake,
    input logic              winLamp,
    input logic              loseLamp,
    input logic [countW-1:0] correct,
    input logic [countW-1:0] incorrect
);

    // A scan that is not aborted lasts five cycles and ends in the score state.
    busyFiveCycles: assert property (@(posedge clk) disable iff (!nRst)
        ($fell(busy) && !$past(gameEnd)) |->
            ($past(busy, 2) && $past(busy, 3) && $past(busy, 4) && $past(busy, 5) &&
             !$past(busy, 6) && !ready))
        else $error("busy did not last five cycles or ready rose too early");

    mistakeOneCycle: assert property (@(posedge clk) disable iff (!nRst) mistake |=> !mistake)
        else $error("mistake pulse lasts more than one cycle");

    oneLamp: assert property (@(posedge clk) disable iff (!nRst) !(winLamp && loseLamp))
        else $error("win and lose lamps are lit together");

    countLimits: assert property (@(posedge clk) disable iff (!nRst)
        (correct <= countW'(winCount)) && (incorrect <= countW'(maxMistakes)))
        else $error("a count is past its limit");

endmodule

bind gameLogic gameLogicAssert uGameLogicAssert (
    .clk       (clk),
    .nRst      (nRst),
    .gameEnd   (gameEnd),
    .ready     (ready),
    .busy      (busy),
    .mistake   (mistake),
    .winLamp   (winLamp),
    .loseLamp  (loseLamp),
    .correct   (correct),
    .incorrect (incorrect)
);

// File: sim/gameChecker.sv
`timescale 1ns/1ps

module gameChecker import wordGamePkg::*; (
    input  logic              clk,
    input  logic              nRst,
    input  logic              checkReq,
    input  logic [countW-1:0] expCorrect,
    input  logic [countW-1:0] expIncorrect,
    input  logic              expWin,
    input  logic              expLose,
    input  logic [wordW-1:0]  expRevealed,
    input  logic [countW-1:0] correct,
    input  logic [countW-1:0] incorrect,
    input  logic              winLamp,
    input  logic              loseLamp,
    input  logic [wordW-1:0]  revealed,
    input  logic [6:0]        segCorrect,
    input  logic [6:0]        segIncorrect,
    input  logic              mistake,
    input  logic              busy,
    output int                errorCount,
    output int                checkCount
);

    int                mistakeSeen;
    int                mistakeWant;
    int                busySeen;
    int                busyWant;
    logic [countW-1:0] lastIncorrect;
    logic [countW-1:0] lastCorrect;

    task automatic compareField(input string name, input logic [wordW-1:0] expVal,
                                input logic [wordW-1:0] actVal);
        if (actVal !== expVal) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s expected %0h, actual %0h",
                     $time, name, expVal, actVal);
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!nRst) begin
            errorCount    = 0;
            checkCount    = 0;
            mistakeSeen   = 0;
            busySeen      = 0;
            lastIncorrect = '0;
            lastCorrect   = '0;
        end else begin
            if (mistake) begin
                mistakeSeen++;
            end
            if (busy) begin
                busySeen++;
            end
            if (checkReq) begin
                // One pulse per added mistake.
                mistakeWant = (expIncorrect > lastIncorrect) ? expIncorrect - lastIncorrect : 0;
                // A scored guess scans every position once.
                busyWant = ((expCorrect > lastCorrect) || (expIncorrect > lastIncorrect)) ?
                           wordLen : 0;
                checkCount++;
                compareField("correct", wordW'(expCorrect), wordW'(correct));
                compareField("incorrect", wordW'(expIncorrect), wordW'(incorrect));
                compareField("winLamp", wordW'(expWin), wordW'(winLamp));
                compareField("loseLamp", wordW'(expLose), wordW'(loseLamp));
                compareField("revealed", expRevealed, revealed);
                compareField("segCorrect", wordW'(segDigits[expCorrect]), wordW'(segCorrect));
                compareField("segIncorrect", wordW'(segDigits[expIncorrect]),
                             wordW'(segIncorrect));
                compareField("mistake pulses", wordW'(mistakeWant), wordW'(mistakeSeen));
                compareField("busy cycles", wordW'(busyWant), wordW'(busySeen));
                lastIncorrect = expIncorrect;
                lastCorrect   = expCorrect;
                mistakeSeen   = 0;
                busySeen      = 0;
            end
        end
    end

endmodule

// File: sim/gameTb.sv
`timescale 1ns/1ps

module gameTb import wordGamePkg::*; ();

    logic               clk;
    logic               nRst;
    logic [letterW-1:0] keyCode;
    logic               keyStrobe;
    logic               startGame;
    logic               gameEnd;
    logic               ready;
    logic               busy;
    logic               mistake;
    logic [countW-1:0]  correct;
    logic [countW-1:0]  incorrect;
    logic [wordW-1:0]   revealed;
    logic [6:0]         segCorrect;
    logic [6:0]         segIncorrect;
    logic               winLamp;
    logic               loseLamp;

    // Expected row for the checker.
    logic               checkReq;
    logic [countW-1:0]  expCorrect;
    logic [countW-1:0]  expIncorrect;
    logic               expWin;
    logic               expLose;
    logic [wordW-1:0]   expRevealed;
    int                 errorCount;
    int                 checkCount;

    logic [67:0]        cases [64];    // Cmd, key, correct, incorrect, win, lose, revealed.
    int                 numCases;
    integer             seed;
    logic               inPlay;

    always #10 clk = ~clk;

    wordGameTop u_dut (.*);

    gameChecker uChecker (.*);

    // ########################################
    // Command driving
    // ########################################

    task automatic waitIdle();
        @(negedge clk);
        while (!(ready && !busy)) begin
            @(negedge clk);
        end
    endtask

    task automatic driveCommand(input logic [3:0] cmd, input logic [7:0] code);
        @(posedge clk);
        #2;
        keyCode   = code;
        keyStrobe = (cmd == 4'h1);
        startGame = (cmd == 4'h2);
        gameEnd   = (cmd == 4'h3);
        @(posedge clk);
        #2;
        keyStrobe = 1'b0;
        startGame = 1'b0;
        gameEnd   = 1'b0;
    endtask

    task automatic runCase(input int idx);
        logic [67:0] row;
        int          gap;
        row = cases[idx];
        gap = {$random(seed)} % 4;
        repeat (gap) @(posedge clk);
        if (inPlay) begin
            waitIdle();
        end
        driveCommand(row[67:64], row[63:56]);
        repeat (9) @(posedge clk);            // Key to counts is eight cycles, lamps one more.
        @(negedge clk);
        if (row[67:64] == 4'h2) begin
            inPlay = ready;                   // Start is ignored without a full word.
        end
        if (row[67:64] == 4'h3) begin
            inPlay = 1'b0;
        end
        if (inPlay) begin
            waitIdle();
        end
        @(posedge clk);
        #2;
        expCorrect   = row[54:52];
        expIncorrect = row[50:48];
        expWin       = row[44];
        expLose      = row[40];
        expRevealed  = row[39:0];
        checkReq     = 1'b1;
        @(posedge clk);
        #2;
        checkReq = 1'b0;
    endtask

    // ########################################
    // Main sequence and watchdog
    // ########################################

    initial begin
        clk          = 1'b0;
        nRst         = 1'b0;
        keyCode      = '0;
        keyStrobe    = 1'b0;
        startGame    = 1'b0;
        gameEnd      = 1'b0;
        checkReq     = 1'b0;
        expCorrect   = '0;
        expIncorrect = '0;
        expWin       = 1'b0;
        expLose      = 1'b0;
        expRevealed  = '0;
        inPlay       = 1'b0;
        seed         = 32'h2474011e;
        numCases     = 0;
        for (int i = 0; i < 64; i++) begin
            cases[i] = '0;
        end
        $readmemh("sim/game_cases.txt", cases);
        while ((numCases < 64) && (cases[numCases][67:64] != 4'h0)) begin
            numCases++;
        end
        repeat (8) @(posedge clk);
        #2;
        nRst = 1'b1;
        for (int i = 0; i < numCases; i++) begin
            runCase(i);
        end
        repeat (2) @(posedge clk);
        if (numCases == 0) begin
            $display("No cases were read from sim/game_cases.txt.");
        end
        $display("Summary: %0d cases, %0d checks, %0d errors", numCases, checkCount, errorCount);
        if ((errorCount == 0) && (numCases > 0) && (checkCount == numCases)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Starts once reset is released, so the case count is final.
    initial begin
        wait (nRst === 1'b1);
        repeat (numCases * 40) @(posedge clk);
        $display("Timeout: the game did not finish all cases in time.");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: sim/game_cases.txt
// Columns: cmd (1 key, 2 start, 3 end) _ key code _ correct _ incorrect _ win _ lose _ revealed
// Loss round with the word CRANE, then a win round with APPLE.
1_63_0_0_0_0_5F5F5F5F5F
1_72_0_0_0_0_5F5F5F5F5F
1_61_0_0_0_0_5F5F5F5F5F
1_6E_0_0_0_0_5F5F5F5F5F
1_65_0_0_0_0_5F5F5F5F5F
2_00_0_0_0_0_5F5F5F5F5F
1_42_0_1_0_0_5F5F5F5F5F
1_44_0_2_0_0_5F5F5F5F5F
1_46_0_3_0_0_5F5F5F5F5F
1_47_0_4_0_0_5F5F5F5F5F
1_48_0_5_0_0_5F5F5F5F5F
1_49_0_6_0_1_5F5F5F5F5F
1_43_0_6_0_1_5F5F5F5F5F
3_00_0_0_0_0_5F5F5F5F5F
1_61_0_0_0_0_5F5F5F5F5F
1_33_0_0_0_0_5F5F5F5F5F
1_50_0_0_0_0_5F5F5F5F5F
1_21_0_0_0_0_5F5F5F5F5F
1_70_0_0_0_0_5F5F5F5F5F
2_00_0_0_0_0_5F5F5F5F5F
1_6C_0_0_0_0_5F5F5F5F5F
1_45_0_0_0_0_5F5F5F5F5F
2_00_0_0_0_0_5F5F5F5F5F
1_70_2_0_0_0_5F50505F5F
1_5A_2_1_0_0_5F50505F5F
1_50_2_2_0_0_5F50505F5F
1_35_2_2_0_0_5F50505F5F
1_61_3_2_0_0_4150505F5F
1_4C_4_2_0_0_4150504C5F
1_65_5_2_1_0_4150504C45
1_58_5_2_1_0_4150504C45

// File: tb.f
hw/wordGamePkg.sv
hw/keyFilter.sv
hw/wordLoader.sv
hw/gameLogic.sv
hw/statusDisplay.sv
hw/wordGameTop.sv
sim/gameLogic_assert.sv
sim/gameChecker.sv
sim/gameTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module gameTb -f tb.f \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/VgameTb > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
